// File: verilog/mem_pkg.sv
// Memory endpoint shared definitions
// Address, line and counter widths plus the read/write arbitration enum

package mem_pkg;

	// Byte address as seen on the request ports
	typedef logic [31:0] addr_t;

	// One full memory line, the data width of every port
	typedef logic [63:0] line_t;

	localparam int unsigned LineBytes      = 8;
	localparam int unsigned LineOffsetBits = $clog2(LineBytes);

	// Occupancy and credit counts, enough for depth 8 plus one
	typedef logic [3:0] count_t;

	// Which request kind won the last arbitration round
	typedef enum logic {
		GRANT_READ,
		GRANT_WRITE
	} grant_e;

endpackage : mem_pkg

// File: verilog/mem_ctrl.sv
// Memory endpoint control
// Aligns request addresses to lines, alternates between reads and writes,
// holds back reads without return buffer credit and pushes write acknowledges

module mem_ctrl #(
	parameter int unsigned ReadLatency = 3,
	parameter int unsigned RetDepth    = 4
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                rd_valid_i,
	input  mem_pkg::addr_t      rd_addr_i,
	output logic                rd_ready_o,
	input  logic                wr_valid_i,
	input  mem_pkg::addr_t      wr_addr_i,
	input  mem_pkg::line_t      wr_data_i,
	output logic                wr_ready_o,
	input  mem_pkg::count_t     ret_count_i,
	input  logic                ack_full_i,
	output logic                cmd_valid_o,
	output logic                cmd_we_o,
	output mem_pkg::addr_t      cmd_addr_o,
	output mem_pkg::line_t      cmd_wdata_o,
	output logic                ack_push_o
);

	localparam mem_pkg::addr_t LineMask = mem_pkg::addr_t'(mem_pkg::LineBytes - 1);

	mem_pkg::addr_t    rd_addr_al;
	mem_pkg::addr_t    wr_addr_al;
	mem_pkg::grant_e   last_grant_q;
	mem_pkg::count_t   inflight_q;
	logic [ReadLatency-1:0] rd_pipe_q;
	logic [4:0]        credit_used;
	logic              rd_credit;
	logic              rd_can;
	logic              wr_can;
	logic              rd_grant;
	logic              wr_grant;

	assign rd_addr_al = rd_addr_i & ~LineMask;
	assign wr_addr_al = wr_addr_i & ~LineMask;

	// Reads in the model plus lines already waiting in the return buffer
	assign credit_used = 5'(inflight_q) + 5'(ret_count_i);
	assign rd_credit   = credit_used < 5'(RetDepth);

	assign rd_can = rd_valid_i & rd_credit;
	assign wr_can = wr_valid_i & ~ack_full_i;

	// Loser of the last round goes first when both can proceed
	assign rd_ready_o = rd_credit & (~wr_can | (last_grant_q == mem_pkg::GRANT_WRITE));
	assign wr_ready_o = ~ack_full_i & (~rd_can | (last_grant_q == mem_pkg::GRANT_READ));

	assign rd_grant = rd_valid_i & rd_ready_o;
	assign wr_grant = wr_valid_i & wr_ready_o;

	assign cmd_valid_o = rd_grant | wr_grant;
	assign cmd_we_o    = wr_grant;
	assign cmd_addr_o  = wr_grant ? wr_addr_al : rd_addr_al;
	assign cmd_wdata_o = wr_data_i;
	assign ack_push_o  = wr_grant;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			last_grant_q <= mem_pkg::GRANT_WRITE;
		end else if (rd_grant) begin
			last_grant_q <= mem_pkg::GRANT_READ;
		end else if (wr_grant) begin
			last_grant_q <= mem_pkg::GRANT_WRITE;
		end
	end

	// Mirrors the model read pipeline so a read leaves the count as it is pushed
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_pipe_q  <= '0;
			inflight_q <= '0;
		end else begin
			rd_pipe_q[0] <= rd_grant;
			for (int i = 1; i < ReadLatency; i++) begin
				rd_pipe_q[i] <= rd_pipe_q[i-1];
			end
			case ({rd_grant, rd_pipe_q[ReadLatency-1]})
				2'b10:   inflight_q <= inflight_q + 1'b1;
				2'b01:   inflight_q <= inflight_q - 1'b1;
				default: inflight_q <= inflight_q;
			endcase
		end
	end

	a_one_winner: assert property (@(posedge clk_i) disable iff (rst_i)
		!(rd_grant && wr_grant))
		else $error("read and write granted in the same cycle");

endmodule : mem_ctrl

// File: verilog/dram_model.sv
// Behavioural DRAM model
// Line-wide array with writes on the accept edge and a fixed-latency
// read pipeline holding up to ReadLatency reads in flight

module dram_model #(
	parameter int unsigned ReadLatency = 3,
	parameter int unsigned MemLines    = 256
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                cmd_valid_i,
	input  logic                cmd_we_i,
	input  mem_pkg::addr_t      cmd_addr_i,
	input  mem_pkg::line_t      cmd_wdata_i,
	output logic                rdata_valid_o,
	output mem_pkg::line_t      rdata_o
);

	localparam int unsigned IdxWidth = (MemLines > 1) ? $clog2(MemLines) : 1;

	mem_pkg::line_t        mem_q [MemLines];
	mem_pkg::line_t        data_q [ReadLatency];
	logic [ReadLatency-1:0] vld_q;
	logic [IdxWidth-1:0]   idx;
	logic                  rd_en;
	logic                  wr_en;

	// Line number folded onto the array
	assign idx = IdxWidth'((cmd_addr_i >> mem_pkg::LineOffsetBits) % MemLines);

	assign rd_en = cmd_valid_i & ~cmd_we_i;
	assign wr_en = cmd_valid_i & cmd_we_i;

	initial begin
		for (int i = 0; i < MemLines; i++) begin
			mem_q[i] = '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			mem_q[idx] <= cmd_wdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= rd_en;
			for (int i = 1; i < ReadLatency; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	// Read data follows its valid bit down the pipe
	always_ff @(posedge clk_i) begin
		if (rd_en) begin
			data_q[0] <= mem_q[idx];
		end
		for (int i = 1; i < ReadLatency; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign rdata_valid_o = vld_q[ReadLatency-1];
	assign rdata_o       = data_q[ReadLatency-1];

endmodule : dram_model

// File: verilog/read_return_fifo.sv
// Read return buffer
// In-order circular buffer between the DRAM model and the read response port

module read_return_fifo #(
	parameter int unsigned RetDepth = 4
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                push_i,
	input  mem_pkg::line_t      push_data_i,
	output logic                rsp_valid_o,
	output mem_pkg::line_t      rsp_data_o,
	input  logic                rsp_ready_i,
	output mem_pkg::count_t     count_o
);

	localparam int unsigned PtrWidth = (RetDepth > 1) ? $clog2(RetDepth) : 1;

	mem_pkg::line_t      buf_q [RetDepth];
	logic [PtrWidth-1:0] rptr_q;
	logic [PtrWidth-1:0] wptr_q;
	mem_pkg::count_t     count_q;
	logic                pop;

	assign rsp_valid_o = count_q != '0;
	assign rsp_data_o  = buf_q[rptr_q];
	assign pop         = rsp_valid_o & rsp_ready_i;
	assign count_o     = count_q;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			buf_q[wptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rptr_q  <= '0;
			wptr_q  <= '0;
			count_q <= '0;
		end else begin
			if (push_i) begin
				wptr_q <= (wptr_q == PtrWidth'(RetDepth - 1)) ? '0 : wptr_q + 1'b1;
			end
			if (pop) begin
				rptr_q <= (rptr_q == PtrWidth'(RetDepth - 1)) ? '0 : rptr_q + 1'b1;
			end
			count_q <= count_q + push_i - pop;
		end
	end

	// Credit in the control block must keep the model from overrunning us
	a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
		push_i |-> (count_q < mem_pkg::count_t'(RetDepth)))
		else $error("read data pushed into a full return buffer");

endmodule : read_return_fifo

// File: verilog/write_resp_queue.sv
// Write acknowledge queue
// Counts pending write acknowledges up to AckDepth and presents them
// one at a time on the acknowledge port

module write_resp_queue #(
	parameter int unsigned AckDepth = 8
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic push_i,
	output logic ack_valid_o,
	input  logic ack_ready_i,
	output logic full_o
);

	mem_pkg::count_t count_q;
	logic            pop;

	assign ack_valid_o = count_q != '0;
	assign full_o      = count_q == mem_pkg::count_t'(AckDepth);
	assign pop         = ack_valid_o & ack_ready_i;

	// Push and pop together leave the count unchanged
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + push_i - pop;
		end
	end

	a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
		full_o |-> !push_i)
		else $error("write acknowledge pushed into a full queue");

	// A wrap below zero would also show up as a count above the depth
	a_count_range: assert property (@(posedge clk_i) disable iff (rst_i)
		count_q <= mem_pkg::count_t'(AckDepth))
		else $error("acknowledge count outside the queue depth");

endmodule : write_resp_queue

// File: verilog/mem_sim_top.sv
// Simulation memory endpoint
// Read and write request ports feed an arbitrated DRAM model, with in-order
// read return and one acknowledge per accepted write

module mem_sim_top #(
	parameter int unsigned ReadLatency = 3,
	parameter int unsigned RetDepth    = 4,
	parameter int unsigned AckDepth    = 8,
	parameter int unsigned MemLines    = 256
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                rd_valid_i,
	input  mem_pkg::addr_t      rd_addr_i,
	output logic                rd_ready_o,
	input  logic                wr_valid_i,
	input  mem_pkg::addr_t      wr_addr_i,
	input  mem_pkg::line_t      wr_data_i,
	output logic                wr_ready_o,
	output logic                rsp_valid_o,
	output mem_pkg::line_t      rsp_data_o,
	input  logic                rsp_ready_i,
	output logic                ack_valid_o,
	input  logic                ack_ready_i
);

	logic            cmd_valid;
	logic            cmd_we;
	mem_pkg::addr_t  cmd_addr;
	mem_pkg::line_t  cmd_wdata;
	logic            rdata_valid;
	mem_pkg::line_t  rdata;
	mem_pkg::count_t ret_count;
	logic            ack_push;
	logic            ack_full;

	mem_ctrl #(.ReadLatency(ReadLatency), .RetDepth(RetDepth)) i_mem_ctrl (
		.clk_i,
		.rst_i,
		.rd_valid_i,
		.rd_addr_i,
		.rd_ready_o,
		.wr_valid_i,
		.wr_addr_i,
		.wr_data_i,
		.wr_ready_o,
		.ret_count_i (ret_count),
		.ack_full_i  (ack_full ),
		.cmd_valid_o (cmd_valid),
		.cmd_we_o    (cmd_we   ),
		.cmd_addr_o  (cmd_addr ),
		.cmd_wdata_o (cmd_wdata),
		.ack_push_o  (ack_push )
	);

	dram_model #(.ReadLatency(ReadLatency), .MemLines(MemLines)) i_dram_model (
		.clk_i,
		.rst_i,
		.cmd_valid_i   (cmd_valid  ),
		.cmd_we_i      (cmd_we     ),
		.cmd_addr_i    (cmd_addr   ),
		.cmd_wdata_i   (cmd_wdata  ),
		.rdata_valid_o (rdata_valid),
		.rdata_o       (rdata      )
	);

	read_return_fifo #(.RetDepth(RetDepth)) i_read_return_fifo (
		.clk_i,
		.rst_i,
		.push_i      (rdata_valid),
		.push_data_i (rdata      ),
		.rsp_valid_o,
		.rsp_data_o,
		.rsp_ready_i,
		.count_o     (ret_count  )
	);

	write_resp_queue #(.AckDepth(AckDepth)) i_write_resp_queue (
		.clk_i,
		.rst_i,
		.push_i      (ack_push),
		.ack_valid_o,
		.ack_ready_i,
		.full_o      (ack_full)
	);

endmodule : mem_sim_top

// File: sim/tb_mem_sim.sv
// Directed testbench for the simulation memory endpoint
// Checks read and write paths, alignment, latency, back-pressure and arbitration
// against a reference memory

module tb_mem_sim;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned ReadLatency = 3;
	localparam int unsigned RetDepth    = 4;
	localparam int unsigned AckDepth    = 8;
	// Rough cycles for reset and each test, then a safety factor of four
	localparam int unsigned TestCycles  = 10 + 90 + 25 + 15 + 30 + 40 + 40;
	localparam int unsigned LimitNs     = TestCycles * 20 * 4;

	logic           clk_i;
	logic           rst_i;
	logic           rd_valid_i;
	mem_pkg::addr_t rd_addr_i;
	logic           rd_ready_o;
	logic           wr_valid_i;
	mem_pkg::addr_t wr_addr_i;
	mem_pkg::line_t wr_data_i;
	logic           wr_ready_o;
	logic           rsp_valid_o;
	mem_pkg::line_t rsp_data_o;
	logic           rsp_ready_i;
	logic           ack_valid_o;
	logic           ack_ready_i;

	mem_pkg::line_t ref_mem [int unsigned];
	mem_pkg::addr_t addr_q [$];
	mem_pkg::line_t exp_q [$];
	mem_pkg::line_t rsp_q [$];
	int unsigned    ack_count = 0;
	int unsigned    value_errs = 0;
	int unsigned    other_errs = 0;
	logic [15:0]    lfsr_q;

	mem_sim_top uut (
		.clk_i       (clk_i      ),
		.rst_i       (rst_i      ),
		.rd_valid_i  (rd_valid_i ),
		.rd_addr_i   (rd_addr_i  ),
		.rd_ready_o  (rd_ready_o ),
		.wr_valid_i  (wr_valid_i ),
		.wr_addr_i   (wr_addr_i  ),
		.wr_data_i   (wr_data_i  ),
		.wr_ready_o  (wr_ready_o ),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o ),
		.rsp_ready_i (rsp_ready_i),
		.ack_valid_o (ack_valid_o),
		.ack_ready_i (ack_ready_i)
	);

	always #10 clk_i = ~clk_i;

	// Outputs are stable just after the falling edge, transfers land on the next rise
	always @(negedge clk_i) begin
		#1;
		if (!rst_i && rsp_valid_o && rsp_ready_i) begin
			rsp_q.push_back(rsp_data_o);
		end
		if (!rst_i && ack_valid_o && ack_ready_i) begin
			ack_count++;
		end
	end

	initial begin
		#(LimitNs);
		$display("Timeout: the tests did not finish within %0d ns", LimitNs);
		$display("Errors found");
		$finish;
	end

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	function automatic logic [63:0] rand_bits(input int unsigned n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		return v;
	endfunction

	// Unwritten lines read as zero
	function automatic mem_pkg::line_t expect_line(input mem_pkg::addr_t addr);
		int unsigned line;
		line = addr >> mem_pkg::LineOffsetBits;
		return ref_mem.exists(line) ? ref_mem[line] : '0;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("Fail %s: expected %h, actual %h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic do_write(input mem_pkg::addr_t addr, input mem_pkg::line_t data);
		wr_valid_i = 1'b1;
		wr_addr_i  = addr;
		wr_data_i  = data;
		#1;
		while (!wr_ready_o) begin
			@(negedge clk_i);
			#1;
		end
		ref_mem[addr >> mem_pkg::LineOffsetBits] = data;
		@(negedge clk_i);
		wr_valid_i = 1'b0;
	endtask

	task automatic do_read(input mem_pkg::addr_t addr);
		rd_valid_i = 1'b1;
		rd_addr_i  = addr;
		#1;
		while (!rd_ready_o) begin
			@(negedge clk_i);
			#1;
		end
		exp_q.push_back(expect_line(addr));
		@(negedge clk_i);
		rd_valid_i = 1'b0;
	endtask

	task automatic check_responses(input string name);
		@(negedge clk_i);
		while (rsp_q.size() < exp_q.size()) begin
			@(negedge clk_i);
		end
		while (exp_q.size() > 0) begin
			check_value(name, exp_q.pop_front(), rsp_q.pop_front());
		end
		assert (rsp_q.size() == 0) else begin
			$display("%s: more read responses arrived than reads were accepted", name);
			other_errs++;
			rsp_q.delete();
		end
	endtask

	task automatic test_write_readback();
		mem_pkg::addr_t addr;
		int unsigned    base;
		base = ack_count;
		addr_q.delete();
		for (int i = 0; i < 16; i++) begin
			addr = mem_pkg::addr_t'(rand_bits(11));
			addr_q.push_back(addr);
			do_write(addr, rand_bits(64));
		end
		while (ack_count < base + 16) begin
			@(negedge clk_i);
		end
		repeat (4) @(negedge clk_i);
		check_value("write_readback acks", 64'(16), 64'(ack_count - base));
		foreach (addr_q[i]) begin
			do_read(addr_q[i]);
		end
		check_responses("write_readback");
	endtask

	task automatic test_unwritten_alias();
		int unsigned line;
		line = 0;
		while (ref_mem.exists(line)) begin
			line++;
		end
		do_read(mem_pkg::addr_t'(line << mem_pkg::LineOffsetBits));
		check_responses("unwritten");
		// Same line, different offsets within it
		do_write(mem_pkg::addr_t'((line << mem_pkg::LineOffsetBits) + 5), rand_bits(64));
		do_read(mem_pkg::addr_t'((line << mem_pkg::LineOffsetBits) + 2));
		check_responses("alias");
	endtask

	task automatic test_read_latency();
		int unsigned n;
		do_read(mem_pkg::addr_t'(rand_bits(11)));
		n = 1;
		#1;
		while (!rsp_valid_o) begin
			@(negedge clk_i);
			#1;
			n++;
		end
		check_value("read_latency cycles", 64'(ReadLatency + 1), 64'(n));
		check_responses("read_latency");
	endtask

	task automatic test_read_backpressure();
		int unsigned n;
		// Lines written by the first test, so each return carries distinct data
		rsp_ready_i = 1'b0;
		rd_valid_i  = 1'b1;
		n = 0;
		for (int c = 0; c < 12; c++) begin
			rd_addr_i = addr_q[n];
			#1;
			if (rd_ready_o) begin
				exp_q.push_back(expect_line(rd_addr_i));
				n++;
			end
			@(negedge clk_i);
		end
		rd_valid_i = 1'b0;
		#1;
		check_value("read_backpressure accepts", 64'(RetDepth), 64'(n));
		check_value("read_backpressure rd_ready", 64'(0), 64'(rd_ready_o));
		@(negedge clk_i);
		rsp_ready_i = 1'b1;
		check_responses("read_backpressure");
	endtask

	task automatic test_ack_backpressure();
		int unsigned n;
		int unsigned base;
		while (ack_valid_o) begin
			@(negedge clk_i);
		end
		ack_ready_i = 1'b0;
		base = ack_count;
		n = 0;
		wr_valid_i = 1'b1;
		wr_addr_i  = mem_pkg::addr_t'(rand_bits(11));
		wr_data_i  = rand_bits(64);
		for (int c = 0; c < 14; c++) begin
			#1;
			if (wr_ready_o) begin
				ref_mem[wr_addr_i >> mem_pkg::LineOffsetBits] = wr_data_i;
				n++;
				@(negedge clk_i);
				wr_addr_i = mem_pkg::addr_t'(rand_bits(11));
				wr_data_i = rand_bits(64);
			end else begin
				@(negedge clk_i);
			end
		end
		wr_valid_i = 1'b0;
		#1;
		check_value("ack_backpressure accepts", 64'(AckDepth), 64'(n));
		check_value("ack_backpressure wr_ready", 64'(0), 64'(wr_ready_o));
		@(negedge clk_i);
		ack_ready_i = 1'b1;
		while (ack_count < base + AckDepth) begin
			@(negedge clk_i);
		end
		repeat (3) @(negedge clk_i);
		check_value("ack_backpressure acks", 64'(AckDepth), 64'(ack_count - base));
	endtask

	task automatic test_contention();
		logic rd_acc;
		logic wr_acc;
		logic last_rd;
		last_rd = 1'b0;
		rd_valid_i = 1'b1;
		wr_valid_i = 1'b1;
		// Reads from the lower half of the lines, writes to the upper half
		rd_addr_i = mem_pkg::addr_t'(rand_bits(10));
		wr_addr_i = mem_pkg::addr_t'(rand_bits(10)) | 32'h400;
		wr_data_i = rand_bits(64);
		for (int c = 0; c < 16; c++) begin
			#1;
			rd_acc = rd_ready_o;
			wr_acc = wr_ready_o;
			assert (rd_acc ^ wr_acc) else begin
				$display("Contention: cycle %0d did not accept exactly one request", c);
				other_errs++;
			end
			if (c > 0) begin
				check_value("contention order", 64'(!last_rd), 64'(rd_acc));
			end
			last_rd = rd_acc;
			if (rd_acc) begin
				exp_q.push_back(expect_line(rd_addr_i));
			end
			if (wr_acc) begin
				ref_mem[wr_addr_i >> mem_pkg::LineOffsetBits] = wr_data_i;
			end
			@(negedge clk_i);
			if (rd_acc) begin
				rd_addr_i = mem_pkg::addr_t'(rand_bits(10));
			end
			if (wr_acc) begin
				wr_addr_i = mem_pkg::addr_t'(rand_bits(10)) | 32'h400;
				wr_data_i = rand_bits(64);
			end
		end
		rd_valid_i = 1'b0;
		wr_valid_i = 1'b0;
		check_responses("contention");
	endtask

	initial begin
		clk_i       = 1'b0;
		rst_i       = 1'b1;
		rd_valid_i  = 1'b0;
		rd_addr_i   = '0;
		wr_valid_i  = 1'b0;
		wr_addr_i   = '0;
		wr_data_i   = '0;
		rsp_ready_i = 1'b1;
		ack_ready_i = 1'b1;
		lfsr_q      = 16'd40;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		#1;
		check_value("reset rsp_valid", 64'(0), 64'(rsp_valid_o));
		check_value("reset ack_valid", 64'(0), 64'(ack_valid_o));
		@(negedge clk_i);
		test_write_readback();
		test_unwritten_alias();
		test_read_latency();
		test_read_backpressure();
		test_ack_backpressure();
		test_contention();
		$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule : tb_mem_sim

// File: project.f
verilog/mem_pkg.sv
verilog/mem_ctrl.sv
verilog/dram_model.sv
verilog/read_return_fifo.sv
verilog/write_resp_queue.sv
verilog/mem_sim_top.sv
sim/tb_mem_sim.sv

// File: Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_mem_sim
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), pass if the log holds the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
